/* rv_multicycle_ctrl.f */
verilog/rv_ctrl_pkg.sv
verilog/immediate_gen.sv
verilog/alu_op_decode.sv
verilog/control_sequencer.sv
verilog/control_unit.sv
testbench/tb_clock.sv
testbench/tb_control_unit.sv

/* Makefile */
TOP = tb_control_unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f rv_multicycle_ctrl.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* testbench/tb_control_unit.sv */
`timescale 1ns/1ps

module tb_control_unit;
    import rv_ctrl_pkg::*;

    logic      aclk;
    logic      reset;
    word_t     inst;
    logic      alu_flag;
    reg_addr_t rd, rs1, rs2;
    word_t     imm;
    alu_op_t   alu_op;
    a_sel_t    a_sel;
    b_sel_t    b_sel;
    c_sel_t    c_sel;
    pc_sel_t   pc_sel;
    logic      pc_enable, ir_enable, cur_pc_enable, wb, m2r_sel, mem_we;

    integer    seed = 32'hb989dd82;
    int        cycle_count;                         // cycles since last fetch began
    int        timing_errors = 0;
    int        decode_errors = 0;
    int        control_errors = 0;
    bit        timed_out = 0;
    state_t    exp_state;                           // modelled sequencer state
    logic [4:0] exp_strobes;                        // ir_enable, cur_pc_enable, wb, mem_we, m2r_sel
    logic      exp_pc_enable;                       // pc written this cycle
    pc_sel_t   exp_pc_sel;
    logic      operand_check;                       // cycle with known alu operands
    a_sel_t    exp_a_sel;
    b_sel_t    exp_b_sel;
    opcode_t   opc;

    localparam alu_op_t branch_ops [8] = '{alu_eq, alu_ne, alu_add, alu_add,
                                           alu_lt, alu_ge, alu_ltu, alu_geu};
    localparam alu_op_t arith_ops [8] = '{alu_add, alu_sll, alu_slt, alu_sltu,
                                          alu_xor, alu_srl, alu_or, alu_and};
    localparam opcode_t op_list [9] = '{op_imm, op_reg, op_branch, op_lui, op_load,
                                        op_store, op_jal, op_jalr, 7'b0001111};

    tb_clock clock_i (.*);
    control_unit control_unit_i (.*);

    assign opc = inst[6:0];

    function automatic int expected_cycles(word_t w);
        logic link;
        link = (w[11:7] != 5'd0);                   // rd nonzero, link written
        case (w[6:0])
            op_lui, op_branch:        return 3;
            op_jal:                   return link ? 3 : 2;
            op_jalr:                  return link ? 4 : 3;
            op_imm, op_reg, op_store: return 4;
            op_load:                  return 5;
            default:                  return 2;     // unknown, straight back to fetch
        endcase
    endfunction

    function automatic word_t expected_imm(word_t w);
        case (w[6:0])
            op_imm, op_load, op_jalr: return word_t'($signed(w) >>> 20);
            op_store:  return (word_t'($signed(w) >>> 20) & ~32'h1f) | {27'b0, w[11:7]};
            op_branch: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            op_lui:    return w & 32'hffff_f000;
            op_jal:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:   return '0;
        endcase
    endfunction

    function automatic alu_op_t expected_alu_op(word_t w);
        opcode_t op;
        funct3_t f3;
        op = w[6:0];
        f3 = w[14:12];
        if (op == op_branch) return branch_ops[f3];
        if (op != op_reg && op != op_imm) return alu_add;
        if (f3 == 3'd0 && op == op_reg && w[30]) return alu_sub;  // register form only
        if (f3 == 3'd5 && w[30]) return alu_sra;
        return arith_ops[f3];
    endfunction

    always @(posedge aclk) begin
        if (reset) cycle_count <= 0;
        else if (ir_enable) cycle_count <= 1;       // decode is cycle 1
        else cycle_count <= cycle_count + 1;
    end

    always_comb begin
        if (cycle_count == 0 || cycle_count >= expected_cycles(inst)) exp_state = st_fetch;
        else if (cycle_count == 1) exp_state = st_decode;
        else if (cycle_count == 2 && (opc == op_lui || opc == op_jal)) exp_state = st_write_back;
        else if (cycle_count == 2) exp_state = st_execute;
        else if (cycle_count == 3 && (opc == op_load || opc == op_store)) exp_state = st_memory;
        else exp_state = st_write_back;
        exp_strobes = {exp_state == st_fetch, exp_state == st_fetch,
                       exp_state == st_write_back,
                       exp_state == st_memory && opc == op_store,
                       exp_state == st_write_back && opc == op_load};
        exp_pc_enable = (exp_state == st_fetch) ||
                        (exp_state == st_decode && opc == op_jal) ||
                        (exp_state == st_execute && opc == op_jalr) ||
                        (exp_state == st_execute && opc == op_branch && alu_flag);
        exp_pc_sel = (exp_state == st_fetch) ? pc_plus4 :
                     (opc == op_branch) ? pc_c : pc_alu;
        // rs1 op rs2 for op and compares, rs1 plus imm otherwise, cur_pc plus imm for jal
        operand_check = (exp_state == st_execute) ||
                        (exp_state == st_decode && opc == op_jal);
        exp_a_sel = (exp_state == st_execute) ? a_reg : a_cur_pc;
        exp_b_sel = (exp_state == st_execute && (opc == op_reg || opc == op_branch)) ?
                    b_reg : b_imm;
    end

    cycles_per_inst: assert property (@(posedge aclk) disable iff (reset)
        ir_enable && cycle_count != 0 |-> cycle_count == expected_cycles(inst))
        else begin
            timing_errors++;
            $display("FAIL cycles: got %h expected %h", $sampled(cycle_count),
                     expected_cycles($sampled(inst)));
        end

    strobes_match: assert property (@(posedge aclk) disable iff (reset)
        {ir_enable, cur_pc_enable, wb, mem_we, m2r_sel} == exp_strobes)
        else begin
            control_errors++;
            $display("FAIL {ir_enable,cur_pc_enable,wb,mem_we,m2r_sel}: got %h expected %h",
                     $sampled({ir_enable, cur_pc_enable, wb, mem_we, m2r_sel}),
                     $sampled(exp_strobes));
        end

    lui_writes_imm: assert property (@(posedge aclk) disable iff (reset)
        exp_state == st_write_back && opc == op_lui |-> c_sel == c_imm)
        else begin
            control_errors++;
            $display("FAIL c_sel: got %h expected %h", $sampled(c_sel), c_imm);
        end

    // taken branches only, plus every fetch and both jumps
    pc_update_matches: assert property (@(posedge aclk) disable iff (reset)
        pc_enable == exp_pc_enable && (!exp_pc_enable || pc_sel == exp_pc_sel))
        else begin
            control_errors++;
            $display("FAIL pc_enable/pc_sel: got %h/%h expected %h/%h", $sampled(pc_enable),
                     $sampled(pc_sel), $sampled(exp_pc_enable), $sampled(exp_pc_sel));
        end

    operands_match: assert property (@(posedge aclk) disable iff (reset)
        operand_check |-> a_sel == exp_a_sel && b_sel == exp_b_sel)
        else begin
            control_errors++;
            $display("FAIL a_sel/b_sel: got %h/%h expected %h/%h", $sampled(a_sel),
                     $sampled(b_sel), $sampled(exp_a_sel), $sampled(exp_b_sel));
        end

    fields_match: assert property (@(posedge aclk)
        {rd, rs1, rs2} == {inst[11:7], inst[19:15], inst[24:20]})
        else begin
            decode_errors++;
            $display("FAIL {rd,rs1,rs2}: got %h expected %h", $sampled({rd, rs1, rs2}),
                     $sampled({inst[11:7], inst[19:15], inst[24:20]}));
        end

    imm_matches: assert property (@(posedge aclk) imm == expected_imm(inst))
        else begin
            decode_errors++;
            $display("FAIL imm: got %h expected %h", $sampled(imm),
                     expected_imm($sampled(inst)));
        end

    alu_op_matches: assert property (@(posedge aclk) alu_op == expected_alu_op(inst))
        else begin
            decode_errors++;
            $display("FAIL alu_op: got %h expected %h", $sampled(alu_op),
                     expected_alu_op($sampled(inst)));
        end

    task automatic wait_fetch();
        int n;
        int rnd;
        n = 0;
        do begin
            @(posedge aclk);
            rnd = $random(seed);
            alu_flag <= rnd[0];                     // new branch outcome every cycle
            n++;
        end while (!ir_enable && n < 10);
        if (!ir_enable) begin
            timed_out = 1;
            $display("timeout: ir_enable did not rise within 10 cycles");
        end
    endtask

    task automatic issue(input opcode_t op, input bit rd_zero, input int f);
        word_t w;
        w = $random(seed);
        w[6:0] = op;
        if (rd_zero) w[11:7] = '0;
        else if (w[11:7] == '0) w[11:7] = 5'd1;
        if (f >= 0) begin                           // forced funct3 and bit 30
            w[14:12] = f[2:0];
            w[30] = f[3];
        end
        if (!timed_out) wait_fetch();
        if (!timed_out) inst <= w;                  // IR loads at end of fetch
    endtask

    initial begin
        int n;
        inst = '0;
        alu_flag = 1'b0;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (reset && n < 20);
        if (reset) begin
            timed_out = 1;
            $display("timeout: reset was never released");
        end
        for (int i = 0; i < 9; i++)                 // every class, rd zero and nonzero
            for (int r = 0; r < 8; r++)
                issue(op_list[i], r[0], -1);
        for (int i = 0; i < 3; i++)                 // op-imm, op, branch decode sweep
            for (int f = 0; f < 16; f++)
                issue(op_list[i], 1'b0, f);
        if (!timed_out) wait_fetch();               // retire the last one
        $display("errors: timing %0d, decode %0d, control %0d, timeouts %0d",
                 timing_errors, decode_errors, control_errors, timed_out);
        if (!timed_out && timing_errors + decode_errors + control_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic aclk,
    output logic reset
);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;                    // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge aclk);                 // held for 4 cycles
        reset <= 1'b0;
    end

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic                   aclk,
    input  logic                   reset,
    input  rv_ctrl_pkg::word_t     inst,          // from instruction register
    input  logic                   alu_flag,
    output rv_ctrl_pkg::reg_addr_t rd,
    output rv_ctrl_pkg::reg_addr_t rs1,
    output rv_ctrl_pkg::reg_addr_t rs2,
    output rv_ctrl_pkg::word_t     imm,
    output rv_ctrl_pkg::alu_op_t   alu_op,
    output rv_ctrl_pkg::a_sel_t    a_sel,
    output rv_ctrl_pkg::b_sel_t    b_sel,
    output rv_ctrl_pkg::c_sel_t    c_sel,
    output rv_ctrl_pkg::pc_sel_t   pc_sel,
    output logic                   pc_enable,
    output logic                   ir_enable,
    output logic                   cur_pc_enable,
    output logic                   wb,
    output logic                   m2r_sel,
    output logic                   mem_we
);
    import rv_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    funct7_b5;                             // sub / sra select

    // instruction fields
    assign opcode    = inst[6:0];
    assign rd        = inst[11:7];
    assign funct3    = inst[14:12];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign funct7_b5 = inst[30];

    immediate_gen immediate_gen_i (
        .inst (inst),
        .imm  (imm)
    );

    alu_op_decode alu_op_decode_i (
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7_b5 (funct7_b5),
        .alu_op    (alu_op)
    );

    control_sequencer control_sequencer_i (
        .aclk          (aclk),
        .reset         (reset),
        .opcode        (opcode),
        .rd            (rd),
        .alu_flag      (alu_flag),
        .a_sel         (a_sel),
        .b_sel         (b_sel),
        .c_sel         (c_sel),
        .pc_sel        (pc_sel),
        .pc_enable     (pc_enable),
        .ir_enable     (ir_enable),
        .cur_pc_enable (cur_pc_enable),
        .wb            (wb),
        .m2r_sel       (m2r_sel),
        .mem_we        (mem_we)
    );

endmodule

/* verilog/control_sequencer.sv */
`timescale 1ns/1ps

module control_sequencer (
    input  logic                   aclk,
    input  logic                   reset,
    input  rv_ctrl_pkg::opcode_t   opcode,
    input  rv_ctrl_pkg::reg_addr_t rd,
    input  logic                   alu_flag,      // branch condition from alu
    output rv_ctrl_pkg::a_sel_t    a_sel,
    output rv_ctrl_pkg::b_sel_t    b_sel,
    output rv_ctrl_pkg::c_sel_t    c_sel,
    output rv_ctrl_pkg::pc_sel_t   pc_sel,
    output logic                   pc_enable,
    output logic                   ir_enable,
    output logic                   cur_pc_enable,
    output logic                   wb,            // regfile write
    output logic                   m2r_sel,       // memory data to regfile
    output logic                   mem_we         // store strobe
);
    import rv_ctrl_pkg::*;

    state_t state;
    state_t next_state;
    logic   rd_zero;                                // jump without link

    assign rd_zero = (rd == '0);

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = st_fetch;
        case (state)
            st_fetch: next_state = st_decode;
            st_decode: begin
                case (opcode)
                    op_lui:  next_state = st_write_back;
                    op_jal:  next_state = rd_zero ? st_fetch : st_write_back;
                    op_imm, op_reg, op_branch, op_load, op_store, op_jalr: begin
                        next_state = st_execute;
                    end
                    default: next_state = st_fetch;     // unknown opcode, skip it
                endcase
            end
            st_execute: begin
                case (opcode)
                    op_imm, op_reg:    next_state = st_write_back;
                    op_load, op_store: next_state = st_memory;
                    op_jalr:           next_state = rd_zero ? st_fetch : st_write_back;
                    default:           next_state = st_fetch;   // branch done here
                endcase
            end
            st_memory: next_state = (opcode == op_load) ? st_write_back : st_fetch;
            st_write_back: next_state = st_fetch;
            default: next_state = st_fetch;
        endcase
    end

    always_comb begin
        a_sel         = a_pc;
        b_sel         = b_reg;
        c_sel         = c_reg;
        pc_sel        = pc_plus4;
        pc_enable     = 1'b0;
        ir_enable     = 1'b0;
        cur_pc_enable = 1'b0;
        wb            = 1'b0;
        m2r_sel       = 1'b0;
        mem_we        = 1'b0;
        case (state)
            st_fetch: begin
                ir_enable     = 1'b1;               // latch instruction
                cur_pc_enable = 1'b1;               // remember its address
                pc_enable     = 1'b1;
                b_sel         = b_four;             // pc + 4
            end
            st_decode: begin
                a_sel = a_cur_pc;                   // cur_pc + imm, branch/jal target
                b_sel = b_imm;
                if (opcode == op_jal) begin
                    pc_sel    = pc_alu;
                    pc_enable = 1'b1;
                end
            end
            st_execute: begin
                a_sel = a_reg;
                b_sel = b_imm;                      // op-imm, load/store address, jalr
                case (opcode)
                    op_reg: b_sel = b_reg;
                    op_branch: begin
                        b_sel     = b_reg;          // compare rs1 with rs2
                        pc_sel    = alu_flag ? pc_c : pc_plus4;
                        pc_enable = alu_flag;       // taken only
                    end
                    op_jalr: begin
                        pc_sel    = pc_alu;
                        pc_enable = 1'b1;
                    end
                    default: ;
                endcase
            end
            st_memory: begin
                a_sel  = a_reg;                     // hold the address
                b_sel  = b_imm;
                mem_we = (opcode == op_store);
            end
            st_write_back: begin
                wb = 1'b1;
                case (opcode)
                    op_lui:          c_sel = c_imm;
                    op_load:         m2r_sel = 1'b1;
                    op_jal, op_jalr: c_sel = c_jump;  // return address
                    default:         c_sel = c_alu;
                endcase
            end
            default: ;
        endcase
    end

    // a store strobe never overlaps a regfile write
    wb_mem_we_exclusive: assert property (
        @(posedge aclk) disable iff (reset) !(wb && mem_we)
    );

    // fetch lasts one cycle and is always followed by decode
    ir_enable_in_fetch: assert property (
        @(posedge aclk) disable iff (reset)
        ir_enable |-> (state == st_fetch) ##1 (state == st_decode && !ir_enable)
    );

    state_legal: assert property (
        @(posedge aclk) disable iff (reset)
        !$isunknown(state) && (state inside {st_fetch, st_decode, st_execute,
                                             st_memory, st_write_back})
    );

endmodule

/* verilog/alu_op_decode.sv */
`timescale 1ns/1ps

module alu_op_decode (
    input  rv_ctrl_pkg::opcode_t opcode,
    input  rv_ctrl_pkg::funct3_t funct3,
    input  logic                 funct7_b5,
    output rv_ctrl_pkg::alu_op_t alu_op
);
    import rv_ctrl_pkg::*;

    logic is_reg;                                   // register-register form

    assign is_reg = (opcode == op_reg);

    always_comb begin
        alu_op = alu_add;                           // loads, stores, jumps, lui
        case (opcode)
            op_branch: begin
                case (funct3)
                    3'b000:  alu_op = alu_eq;
                    3'b001:  alu_op = alu_ne;
                    3'b100:  alu_op = alu_lt;
                    3'b101:  alu_op = alu_ge;
                    3'b110:  alu_op = alu_ltu;
                    3'b111:  alu_op = alu_geu;
                    default: alu_op = alu_add;      // reserved encodings
                endcase
            end
            op_reg, op_imm: begin
                case (funct3)
                    // no subi, so sub only for the register form
                    3'b000:  alu_op = (is_reg && funct7_b5) ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = funct7_b5 ? alu_sra : alu_srl;  // srai shares bit 30
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: alu_op = alu_add;
                endcase
            end
            default: begin
                alu_op = alu_add;
            end
        endcase
    end

endmodule

/* verilog/immediate_gen.sv */
`timescale 1ns/1ps

module immediate_gen (
    input  rv_ctrl_pkg::word_t inst,
    output rv_ctrl_pkg::word_t imm
);
    import rv_ctrl_pkg::*;

    opcode_t opcode;
    logic    sign;                                  // immediate sign, always inst[31]

    assign opcode = inst[6:0];
    assign sign   = inst[31];

    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr: begin         // I format
                imm = {{20{sign}}, inst[31:20]};
            end
            op_store: begin                         // S format, split field
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            op_branch: begin                        // B format, bit 0 implied zero
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            op_lui: begin                           // U format, upper 20 bits
                imm = {inst[31:12], 12'b0};
            end
            op_jal: begin                           // J format
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;                           // R type and unknown
            end
        endcase
    end

endmodule

/* verilog/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    localparam int xlen       = 32;                 // RV32 word
    localparam int reg_addr_w = 5;                  // 32 architectural registers
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;

    typedef logic [xlen-1:0]       word_t;          // data or instruction word
    typedef logic [reg_addr_w-1:0] reg_addr_t;      // register file index
    typedef logic [opcode_w-1:0]   opcode_t;        // major opcode
    typedef logic [funct3_w-1:0]   funct3_t;        // minor operation

    // major opcodes handled by the sequencer
    localparam opcode_t op_imm    = 7'b0010011;     // register-immediate alu
    localparam opcode_t op_reg    = 7'b0110011;     // register-register alu
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_eq   = 4'd10,                           // branch compares from here on
        alu_ne   = 4'd11,
        alu_lt   = 4'd12,
        alu_ge   = 4'd13,
        alu_ltu  = 4'd14,
        alu_geu  = 4'd15
    } alu_op_t;

    typedef enum logic [1:0] {
        a_pc     = 2'b00,                           // pc register
        a_reg    = 2'b01,                           // qa from regfile
        a_cur_pc = 2'b10                            // address of current instruction
    } a_sel_t;

    typedef enum logic [1:0] {
        b_reg  = 2'b00,                             // qb from regfile
        b_imm  = 2'b01,
        b_four = 2'b10                              // constant 4
    } b_sel_t;

    typedef enum logic [1:0] {
        c_reg  = 2'b00,
        c_alu  = 2'b01,                             // alu result
        c_jump = 2'b10,                             // link address
        c_imm  = 2'b11
    } c_sel_t;

    typedef enum logic [1:0] {
        pc_plus4 = 2'b00,
        pc_alu   = 2'b01,                           // computed jump target
        pc_c     = 2'b10                            // branch target held in c
    } pc_sel_t;

    typedef enum logic [2:0] {
        st_fetch      = 3'b000,
        st_decode     = 3'b001,
        st_execute    = 3'b010,
        st_memory     = 3'b011,
        st_write_back = 3'b100
    } state_t;

endpackage
